/* audio_mixer.f */
+incdir+rtl
rtl/audio_pkg.sv
rtl/mixer_apb_regs.sv
rtl/audio_gain_mix.sv
rtl/dac_output_stage.sv
rtl/audio_mixer_top.sv
sim/audio_mixer_asserts.sv
sim/tb_audio_mixer.sv

/* rtl/audio_gain_mix.sv */
// Valid strobes have no back-pressure, so a newer sample overwrites a captured one not yet mixed
`include "audio_mixer_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module audio_gain_mix
	import audio_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,

	input  logic        fm_valid,
	input  fm_sample_t  fm_left,
	input  fm_sample_t  fm_right,
	input  logic        psg_valid,
	input  psg_sample_t psg_sample,

	input  logic        fm_en,
	input  logic        psg_en,

	output dac_word_t   mix_left,
	output dac_word_t   mix_right,
	output logic        clip_l,
	output logic        clip_r
);

	localparam logic [1:0] EN_INIT = 2'(`AM_CTRL_RESET);
	localparam mix_acc_t ACC_MAX = mix_acc_t'(32767);
	localparam mix_acc_t ACC_MIN = mix_acc_t'(-32768);

	fm_sample_t  fm_l_cap;
	fm_sample_t  fm_r_cap;
	psg_sample_t psg_cap;
	logic        new_item;
	logic        fm_en_q;
	logic        psg_en_q;
	logic        mix_go;
	mix_acc_t    psg_ext;
	mix_acc_t    psg_part;
	mix_acc_t    fm_part_l;
	mix_acc_t    fm_part_r;
	mix_acc_t    sum_l;
	mix_acc_t    sum_r;

	// FM times 22.25 as 16x + 4x + 2x + x/4
	function automatic mix_acc_t fm_gain(input fm_sample_t s);
		mix_acc_t x;
		x = mix_acc_t'(s);
		return (x <<< 4) + (x <<< 2) + (x <<< 1) + (x >>> 2);
	endfunction

	function automatic logic over_range(input mix_acc_t v);
		return (v > ACC_MAX) || (v < ACC_MIN);
	endfunction

	function automatic dac_word_t saturate(input mix_acc_t v);
		if (v > ACC_MAX) begin
			return dac_word_t'(16'h7FFF);
		end else if (v < ACC_MIN) begin
			return dac_word_t'(16'h8000);
		end
		return dac_word_t'(v[15:0]);
	endfunction

	// ------------------------------------------------------------------------
	// Capture
	// ------------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			fm_l_cap <= '0;
			fm_r_cap <= '0;
			psg_cap  <= '0;
			new_item <= 1'b0;
			fm_en_q  <= EN_INIT[0];
			psg_en_q <= EN_INIT[1];
		end else begin
			if (fm_valid) begin
				fm_l_cap <= fm_left;
				fm_r_cap <= fm_right;
			end
			if (psg_valid) begin
				psg_cap <= psg_sample;
			end
			new_item <= fm_valid | psg_valid;
			fm_en_q  <= fm_en;
			psg_en_q <= psg_en;
		end
	end

	// ------------------------------------------------------------------------
	// Gain and mix
	// ------------------------------------------------------------------------

	// Remix on a fresh capture or on any enable change
	assign mix_go = new_item | (fm_en != fm_en_q) | (psg_en != psg_en_q);

	// PSG is shared by both channels
	assign psg_ext  = mix_acc_t'(psg_cap);
	assign psg_part = psg_en ?
		((psg_ext - (psg_ext >>> `AM_PSG_ATTEN_SHIFT)) <<< `AM_PSG_SHIFT) : mix_acc_t'(0);

	assign fm_part_l = fm_en ? fm_gain(fm_l_cap) : mix_acc_t'(0);
	assign fm_part_r = fm_en ? fm_gain(fm_r_cap) : mix_acc_t'(0);
	assign sum_l     = fm_part_l + psg_part;
	assign sum_r     = fm_part_r + psg_part;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			mix_left  <= '0;
			mix_right <= '0;
			clip_l    <= 1'b0;
			clip_r    <= 1'b0;
		end else begin
			// Clip pulses only with a fresh result
			clip_l <= mix_go & over_range(sum_l);
			clip_r <= mix_go & over_range(sum_r);
			if (mix_go) begin
				mix_left  <= saturate(sum_l);
				mix_right <= saturate(sum_r);
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/audio_mixer_settings.svh */
// Fixed at build time. AM_DAC_DIV must be 2 or more, and the addresses are APB byte offsets
`ifndef AUDIO_MIXER_SETTINGS_SVH
`define AUDIO_MIXER_SETTINGS_SVH

// MCLK cycles per DAC sample, same ratio as the FM clock enable
`define AM_DAC_DIV 7

// PSG gain: attenuate by 1/32, then lift into the FM range
`define AM_PSG_SHIFT 4
`define AM_PSG_ATTEN_SHIFT 5

// Register map
`define AM_ADDR_CTRL 0
`define AM_ADDR_STATUS 4

// CTRL after reset: bit 0 fm_en, bit 1 psg_en
`define AM_CTRL_RESET 3

`endif

/* rtl/audio_mixer_top.sv */
// Samples arrive as strobed inputs from external FM and PSG cores; no filtering on the DAC path
`timescale 1ns/1ps
`default_nettype none

module audio_mixer_top
	import audio_pkg::*;
(
	input  logic        MCLK,
	input  logic        reset,

	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  apb_addr_t   paddr,
	input  apb_data_t   pwdata,
	output apb_data_t   prdata,
	output logic        pready,
	output logic        pslverr,

	input  logic        fm_valid,
	input  fm_sample_t  fm_left,
	input  fm_sample_t  fm_right,
	input  logic        psg_valid,
	input  psg_sample_t psg_sample,

	output dac_word_t   dac_left,
	output dac_word_t   dac_right,
	output logic        dac_strobe
);

	logic      fm_en;
	logic      psg_en;
	logic      clip_l;
	logic      clip_r;
	dac_word_t mix_left;
	dac_word_t mix_right;

	// Control and clip status
	mixer_apb_regs u_regs (
		.MCLK    (MCLK),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.clip_l  (clip_l),
		.clip_r  (clip_r),
		.fm_en   (fm_en),
		.psg_en  (psg_en)
	);

	audio_gain_mix u_mix (
		.MCLK       (MCLK),
		.reset      (reset),
		.fm_valid   (fm_valid),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.psg_valid  (psg_valid),
		.psg_sample (psg_sample),
		.fm_en      (fm_en),
		.psg_en     (psg_en),
		.mix_left   (mix_left),
		.mix_right  (mix_right),
		.clip_l     (clip_l),
		.clip_r     (clip_r)
	);

	dac_output_stage u_dac (
		.MCLK       (MCLK),
		.reset      (reset),
		.mix_left   (mix_left),
		.mix_right  (mix_right),
		.dac_left   (dac_left),
		.dac_right  (dac_right),
		.dac_strobe (dac_strobe)
	);

endmodule

`default_nettype wire

/* rtl/audio_pkg.sv */
// Sample widths follow the FM and PSG cores; the accumulator holds 22.25x FM plus PSG
`default_nettype none

package audio_pkg;

	// ------------------------------------------------------------------------
	// Audio samples
	// ------------------------------------------------------------------------

	// Stereo FM output, one word per channel
	typedef logic signed [15:0] fm_sample_t;

	// Mono PSG output
	typedef logic signed [10:0] psg_sample_t;

	// Full-scale FM times 22.25 plus scaled PSG still fits
	typedef logic signed [21:0] mix_acc_t;

	// Word handed to the DAC
	typedef logic signed [15:0] dac_word_t;

	// ------------------------------------------------------------------------
	// APB
	// ------------------------------------------------------------------------

	typedef logic [3:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

endpackage

`default_nettype wire

/* rtl/dac_output_stage.sv */
// Free-running strobe every AM_DAC_DIV MCLK cycles; the DAC cannot stall, mix words in between are lost
`include "audio_mixer_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module dac_output_stage
	import audio_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,

	input  dac_word_t mix_left,
	input  dac_word_t mix_right,

	output dac_word_t dac_left,
	output dac_word_t dac_right,
	output logic      dac_strobe
);

	localparam int CNT_W = $clog2(`AM_DAC_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`AM_DAC_DIV - 1);

	logic [CNT_W-1:0] div_cnt;

	// ------------------------------------------------------------------------
	// Rate divider
	// ------------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			div_cnt    <= '0;
			dac_strobe <= 1'b0;
		end else begin
			dac_strobe <= (div_cnt == CNT_LAST);
			if (div_cnt == CNT_LAST) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Output words, held between strobes
	always_ff @(posedge MCLK) begin
		if (reset) begin
			dac_left  <= '0;
			dac_right <= '0;
		end else if (dac_strobe) begin
			dac_left  <= mix_left;
			dac_right <= mix_right;
		end
	end

endmodule

`default_nettype wire

/* rtl/mixer_apb_regs.sv */
// APB3 slave with no wait states; unmapped addresses give pslverr, read zero, ignore writes
`include "audio_mixer_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mixer_apb_regs
	import audio_pkg::*;
(
	input  logic      MCLK,
	input  logic      reset,

	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,

	input  logic      clip_l,
	input  logic      clip_r,
	output logic      fm_en,
	output logic      psg_en
);

	localparam logic [1:0] CTRL_INIT = 2'(`AM_CTRL_RESET);

	logic access;
	logic sel_ctrl;
	logic sel_status;
	logic wr_ctrl;
	logic wr_status;
	logic clip_l_flag;
	logic clip_r_flag;

	// ------------------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------------------

	assign access     = psel & penable;
	assign sel_ctrl   = (paddr == apb_addr_t'(`AM_ADDR_CTRL));
	assign sel_status = (paddr == apb_addr_t'(`AM_ADDR_STATUS));
	assign wr_ctrl    = access & pwrite & sel_ctrl;
	assign wr_status  = access & pwrite & sel_status;

	// Transfers always finish in the access cycle
	assign pready  = 1'b1;
	assign pslverr = access & ~(sel_ctrl | sel_status);

	always_comb begin
		prdata = '0;
		if (sel_ctrl) begin
			prdata[1:0] = {psg_en, fm_en};
		end else if (sel_status) begin
			prdata[1:0] = {clip_r_flag, clip_l_flag};
		end
	end

	// ------------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------------

	always_ff @(posedge MCLK) begin
		if (reset) begin
			fm_en  <= CTRL_INIT[0];
			psg_en <= CTRL_INIT[1];
		end else if (wr_ctrl) begin
			fm_en  <= pwdata[0];
			psg_en <= pwdata[1];
		end
	end

	// Sticky, write 1 to clear; a new clip in the same cycle keeps the flag set
	always_ff @(posedge MCLK) begin
		if (reset) begin
			clip_l_flag <= 1'b0;
			clip_r_flag <= 1'b0;
		end else begin
			clip_l_flag <= clip_l | (clip_l_flag & ~(wr_status & pwdata[0]));
			clip_r_flag <= clip_r | (clip_r_flag & ~(wr_status & pwdata[1]));
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the audio mixer testbench with Verilator and run it from the project root.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f audio_mixer.f --top-module tb_audio_mixer -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_audio_mixer
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0

/* sim/audio_mixer_asserts.sv */
// Bound to audio_mixer_top; strobe spacing is checked only after the first strobe following reset
`include "audio_mixer_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module audio_mixer_asserts (
	input wire logic MCLK,
	input wire logic reset,
	input wire logic psel,
	input wire logic penable,
	input wire logic pready,
	input wire logic pslverr,
	input wire logic dac_strobe
);

	logic [7:0] gap;
	logic       seen;

	// Cycles since the last DAC strobe
	always_ff @(posedge MCLK) begin
		if (reset) begin
			gap  <= 8'd0;
			seen <= 1'b0;
		end else if (dac_strobe) begin
			gap  <= 8'd1;
			seen <= 1'b1;
		end else begin
			gap <= gap + 8'd1;
		end
	end

	a_strobe_spacing: assert property (@(posedge MCLK) disable iff (reset)
		(dac_strobe && seen) |-> (gap == 8'(`AM_DAC_DIV)))
		else $error("DAC strobes arrived at the wrong spacing");

	a_strobe_late: assert property (@(posedge MCLK) disable iff (reset)
		seen |-> (gap <= 8'(`AM_DAC_DIV)))
		else $error("DAC strobe missing after the divide period");

	a_pready: assert property (@(posedge MCLK) disable iff (reset)
		(psel && penable) |-> pready)
		else $error("pready low during an APB access phase");

	a_pslverr: assert property (@(posedge MCLK) disable iff (reset)
		!(psel && penable) |-> !pslverr)
		else $error("pslverr high outside an APB access phase");

	a_strobe_reset: assert property (@(posedge MCLK)
		reset |=> !dac_strobe)
		else $error("DAC strobe high during reset");

endmodule

bind audio_mixer_top audio_mixer_asserts u_asserts (
	.MCLK       (MCLK),
	.reset      (reset),
	.psel       (psel),
	.penable    (penable),
	.pready     (pready),
	.pslverr    (pslverr),
	.dac_strobe (dac_strobe)
);

`default_nettype wire

/* sim/tb_audio_mixer.sv */
// Self-checking; every wait gives up after 50 cycles and the first error stops the run
`include "audio_mixer_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_audio_mixer
	import audio_pkg::*;
();

	localparam int WAIT_LIMIT = 50;

	logic        MCLK;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata;
	apb_data_t   prdata;
	logic        pready;
	logic        pslverr;
	logic        fm_valid;
	fm_sample_t  fm_left;
	fm_sample_t  fm_right;
	logic        psg_valid;
	psg_sample_t psg_sample;
	dac_word_t   dac_left;
	dac_word_t   dac_right;
	logic        dac_strobe;

	// Model of what the DUT currently holds
	fm_sample_t  cur_fm_l;
	fm_sample_t  cur_fm_r;
	psg_sample_t cur_psg;
	logic        cur_fm_en;
	logic        cur_psg_en;
	logic [15:0] lfsr_state;
	logic [15:0] bits_l;
	logic [15:0] bits_r;
	logic [15:0] bits_p;
	apb_data_t   rd;
	logic        err;

	audio_mixer_top u_dut (
		.MCLK       (MCLK),
		.reset      (reset),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.fm_valid   (fm_valid),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.psg_valid  (psg_valid),
		.psg_sample (psg_sample),
		.dac_left   (dac_left),
		.dac_right  (dac_right),
		.dac_strobe (dac_strobe)
	);

	always #5 MCLK = ~MCLK;

	// ------------------------------------------------------------------------
	// Reference model and random source
	// ------------------------------------------------------------------------

	// FM at 22.25x, PSG at 31/32 lifted by 16, clamped to 16 bits
	function automatic dac_word_t ref_mix(input fm_sample_t fm, input psg_sample_t psg,
			input logic fm_on, input logic psg_on);
		int fm_v;
		int psg_v;
		int total;
		fm_v  = int'(fm);
		psg_v = int'(psg);
		total = 0;
		if (fm_on) begin
			total = total + 22 * fm_v + (fm_v >>> 2);
		end
		if (psg_on) begin
			total = total + ((psg_v - (psg_v >>> `AM_PSG_ATTEN_SHIFT)) <<< `AM_PSG_SHIFT);
		end
		if (total > 32767) begin
			return dac_word_t'(16'h7FFF);
		end else if (total < -32768) begin
			return dac_word_t'(16'h8000);
		end
		return dac_word_t'(total);
	endfunction

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	// ------------------------------------------------------------------------
	// Compare and stop
	// ------------------------------------------------------------------------

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_dac(input string name, input dac_word_t expected,
			input dac_word_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_reg(input string name, input apb_data_t expected,
			input apb_data_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	task automatic check_err(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
		end
	endtask

	// ------------------------------------------------------------------------
	// Bus and sample drivers
	// ------------------------------------------------------------------------

	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic slverr);
		int cycles;
		cycles = 0;
		@(posedge MCLK);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge MCLK);
		#1;
		penable = 1'b1;
		// Sample mid-cycle, away from the edges
		#4;
		while (!pready) begin
			@(posedge MCLK);
			#5;
			cycles++;
			if (cycles >= WAIT_LIMIT) begin
				stop_run("APB transfer never completed, pready stayed low");
			end
		end
		rdata  = prdata;
		slverr = pslverr;
		@(posedge MCLK);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_write(input apb_addr_t addr, input apb_data_t wdata, output logic slverr);
		apb_data_t unused;
		apb_access(1'b1, addr, wdata, unused, slverr);
	endtask

	task automatic reg_read(input apb_addr_t addr, output apb_data_t rdata, output logic slverr);
		apb_access(1'b0, addr, '0, rdata, slverr);
	endtask

	// Output words load on the edge after each strobe
	task automatic wait_strobes(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count) begin
			@(posedge MCLK);
			#1;
			cycles++;
			if (dac_strobe) begin
				seen++;
				cycles = 0;
			end
			if (cycles >= WAIT_LIMIT) begin
				stop_run("No DAC strobe arrived within the timeout");
			end
		end
		@(posedge MCLK);
		#1;
	endtask

	task automatic drive_samples(input fm_sample_t l, input fm_sample_t r, input psg_sample_t p);
		@(posedge MCLK);
		#1;
		fm_valid   = 1'b1;
		fm_left    = l;
		fm_right   = r;
		psg_valid  = 1'b1;
		psg_sample = p;
		@(posedge MCLK);
		#1;
		fm_valid  = 1'b0;
		psg_valid = 1'b0;
		cur_fm_l  = l;
		cur_fm_r  = r;
		cur_psg   = p;
		wait_strobes(2);
	endtask

	task automatic set_ctrl(input logic fm_on, input logic psg_on);
		logic slverr;
		reg_write(apb_addr_t'(`AM_ADDR_CTRL), apb_data_t'({psg_on, fm_on}), slverr);
		check_err("ctrl write pslverr", 1'b0, slverr);
		cur_fm_en  = fm_on;
		cur_psg_en = psg_on;
		wait_strobes(2);
	endtask

	task automatic check_outputs(input string name);
		check_dac({name, " left"}, ref_mix(cur_fm_l, cur_psg, cur_fm_en, cur_psg_en), dac_left);
		check_dac({name, " right"}, ref_mix(cur_fm_r, cur_psg, cur_fm_en, cur_psg_en),
			dac_right);
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial begin
		MCLK       = 1'b0;
		reset      = 1'b1;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		fm_valid   = 1'b0;
		fm_left    = '0;
		fm_right   = '0;
		psg_valid  = 1'b0;
		psg_sample = '0;
		cur_fm_l   = '0;
		cur_fm_r   = '0;
		cur_psg    = '0;
		cur_fm_en  = 1'b1;
		cur_psg_en = 1'b1;
		lfsr_state = 16'd54;

		repeat (3) @(posedge MCLK);
		#1;
		reset = 1'b0;

		// First strobe shows the DUT has left reset
		wait_strobes(1);

		// 1. Reset values
		reg_read(apb_addr_t'(`AM_ADDR_CTRL), rd, err);
		check_reg("reset ctrl", apb_data_t'(`AM_CTRL_RESET), rd);
		check_err("reset ctrl pslverr", 1'b0, err);
		reg_read(apb_addr_t'(`AM_ADDR_STATUS), rd, err);
		check_reg("reset status", '0, rd);
		check_dac("reset left", '0, dac_left);
		check_dac("reset right", '0, dac_right);

		// 2. Random samples with both sources on
		for (int i = 0; i < 20; i++) begin
			draw_bits(16, bits_l);
			draw_bits(16, bits_r);
			draw_bits(11, bits_p);
			drive_samples(fm_sample_t'(bits_l), fm_sample_t'(bits_r),
				psg_sample_t'(bits_p[10:0]));
			check_outputs($sformatf("random %0d", i));
		end

		// 3. Enable combinations on a fixed sample set
		drive_samples(fm_sample_t'(1000), fm_sample_t'(-1200), psg_sample_t'(300));
		check_outputs("fixed both on");
		set_ctrl(1'b1, 1'b0);
		check_outputs("fm only");
		set_ctrl(1'b0, 1'b1);
		check_outputs("psg only");
		set_ctrl(1'b0, 1'b0);
		check_outputs("both off");
		check_dac("both off left zero", '0, dac_left);

		// 4. Clamping and sticky clip flags
		set_ctrl(1'b1, 1'b1);
		reg_write(apb_addr_t'(`AM_ADDR_STATUS), apb_data_t'(3), err);
		reg_read(apb_addr_t'(`AM_ADDR_STATUS), rd, err);
		check_reg("status cleared before clip", '0, rd);
		drive_samples(fm_sample_t'(16'h7FFF), fm_sample_t'(16'h8000), psg_sample_t'(0));
		check_dac("clip left max", dac_word_t'(16'h7FFF), dac_left);
		check_dac("clip right min", dac_word_t'(16'h8000), dac_right);
		reg_read(apb_addr_t'(`AM_ADDR_STATUS), rd, err);
		check_reg("clip flags set", apb_data_t'(3), rd);
		reg_write(apb_addr_t'(`AM_ADDR_STATUS), apb_data_t'(3), err);
		reg_read(apb_addr_t'(`AM_ADDR_STATUS), rd, err);
		check_reg("clip flags cleared", '0, rd);

		// 5. Unmapped address
		reg_read(apb_addr_t'(8), rd, err);
		check_err("unmapped read pslverr", 1'b1, err);
		check_reg("unmapped read data", '0, rd);
		reg_write(apb_addr_t'(8), apb_data_t'(0), err);
		check_err("unmapped write pslverr", 1'b1, err);
		reg_read(apb_addr_t'(`AM_ADDR_CTRL), rd, err);
		check_reg("ctrl after unmapped write", apb_data_t'(3), rd);
		check_err("ctrl read pslverr", 1'b0, err);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
